//--- verilog/cnn_consts.svh
`ifndef CNN_CONSTS_SVH
`define CNN_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Frame geometry
////////////////////////////////////////////////////////////////////////////

`define LINE_LEN 16           // Pixels per image row, sizes the line memories

////////////////////////////////////////////////////////////////////////////
// Field widths
////////////////////////////////////////////////////////////////////////////

`define PIX_W   8
`define WGT_W   8
`define BIAS_W  16
`define SHIFT_W 4
`define ROWS_W  8
`define RES_W   16

// Instruction word, packed from the low end
`define INST_W         101
`define INST_WGT_LSB   0      // Nine taps, tap 0 top-left, row-major
`define INST_BIAS_LSB  72
`define INST_SHIFT_LSB 88
`define INST_RELU_BIT  92
`define INST_ROWS_LSB  93

`endif

//--- verilog/cnn_data_pkg.sv
`include "cnn_consts.svh"

package cnn_data_pkg;

	// Feature map side
	typedef logic [`PIX_W-1:0] pixel_t;          // Unsigned input pixel

	// Kernel and bias
	typedef logic signed [`WGT_W-1:0] weight_t;
	typedef logic signed [`BIAS_W-1:0] bias_t;

	// Datapath widths
	typedef logic signed [`PIX_W+`WGT_W:0] product_t;   // Unsigned pixel times signed tap
	typedef logic signed [23:0] acc_t;                   // Nine products plus bias, with headroom

	// Output of the engine after saturation
	typedef logic signed [`RES_W-1:0] result_t;

endpackage

//--- verilog/cnn_ctrl_pkg.sv
`include "cnn_consts.svh"

package cnn_ctrl_pkg;

	typedef logic [`SHIFT_W-1:0] shift_t;
	typedef logic [`ROWS_W-1:0] rows_t;
	typedef logic [`INST_W-1:0] inst_t;

	typedef enum logic [1:0] {
		IDLE,     // Waiting for an instruction
		RUN,      // Taking pixels of the frame
		DRAIN     // Last pixel in, PE still busy
	} dec_state_t;

endpackage

//--- verilog/inst_decode.sv
`include "cnn_consts.svh"

module inst_decode
	import cnn_data_pkg::*, cnn_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       inst_empty,
	input  inst_t      inst,
	output logic       inst_req,
	input  logic       pix_valid,
	input  logic       stall,
	input  logic       pe_busy,
	output logic       pix_ready,
	output logic       frame_start,
	output weight_t    weights [9],
	output bias_t      bias,
	output shift_t     shift,
	output logic       relu
);

	localparam int CNT_W = `ROWS_W + $clog2(`LINE_LEN);

	dec_state_t state;
	rows_t inst_rows;
	logic [CNT_W-1:0] pix_cnt;
	logic [CNT_W-1:0] pix_total;    // rows x LINE_LEN of the current frame
	logic pix_take;
	logic last_pix;

	assign inst_rows = inst[`INST_ROWS_LSB +: `ROWS_W];
	assign pix_ready = (state == RUN) && !stall;
	assign pix_take = pix_valid && pix_ready;
	assign last_pix = (pix_cnt == pix_total - 1'b1);
	assign frame_start = inst_req;     // Window restarts on the capture edge

	////////////////////////////////////////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			inst_req <= 1'b0;
			pix_cnt <= '0;
		end else begin
			inst_req <= 1'b0;     // One cycle pulse
			case (state)
				IDLE: begin
					if (inst_req) begin
						state <= RUN;
						pix_cnt <= '0;
					end else if (!inst_empty) begin
						inst_req <= 1'b1;
					end
				end
				RUN: begin
					if (pix_take) begin
						pix_cnt <= pix_cnt + 1'b1;
						if (last_pix)
							state <= DRAIN;
					end
				end
				DRAIN: begin
					// Wait until the last window has left the PE
					if (!pe_busy)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Frame configuration, loaded with the word it came from
	always_ff @(posedge clk) begin
		if (inst_req) begin
			for (int i = 0; i < 9; i++)
				weights[i] <= inst[`INST_WGT_LSB + i*`WGT_W +: `WGT_W];
			bias <= inst[`INST_BIAS_LSB +: `BIAS_W];
			shift <= inst[`INST_SHIFT_LSB +: `SHIFT_W];
			relu <= inst[`INST_RELU_BIT];
			pix_total <= CNT_W'(inst_rows * `LINE_LEN);
		end
	end

endmodule

//--- verilog/line_window.sv
`include "cnn_consts.svh"

module line_window
	import cnn_data_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   frame_start,
	input  pixel_t pix,
	input  logic   pix_take,
	input  logic   stall,
	output pixel_t win [9],
	output logic   win_valid
);

	localparam int COL_W = $clog2(`LINE_LEN);
	localparam logic [COL_W-1:0] COL_LAST = COL_W'(`LINE_LEN - 1);

	pixel_t line_mem [2][`LINE_LEN];    // Rows r-1 and r-2, ping-pong
	logic newer_sel;                    // Memory holding row r-1
	logic older_sel;
	logic [COL_W-1:0] col;
	logic [1:0] row;                    // Saturates at 2
	pixel_t older_pix;
	pixel_t newer_pix;
	logic shift_en;
	logic win_hit;

	assign older_sel = ~newer_sel;
	assign older_pix = line_mem[older_sel][col];
	assign newer_pix = line_mem[newer_sel][col];
	assign shift_en = pix_take && !stall;

	// Three full columns and three full rows behind this pixel
	assign win_hit = (col >= COL_W'(2)) && (row == 2'd2);

	////////////////////////////////////////////////////////////////////////////
	// Line memories and window
	////////////////////////////////////////////////////////////////////////////

	// The new pixel overwrites row r-2, which becomes the newer line next row
	always_ff @(posedge clk) begin
		if (shift_en)
			line_mem[older_sel][col] <= pix;
	end

	always_ff @(posedge clk) begin
		if (shift_en) begin
			for (int r = 0; r < 3; r++) begin
				win[r*3] <= win[r*3 + 1];
				win[r*3 + 1] <= win[r*3 + 2];
			end
			win[2] <= older_pix;    // Top row
			win[5] <= newer_pix;
			win[8] <= pix;          // Bottom row, straight from the stream
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Position tracking
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			col <= '0;
			row <= '0;
			newer_sel <= 1'b0;
			win_valid <= 1'b0;
		end else if (!stall) begin
			win_valid <= shift_en && win_hit;
			if (frame_start) begin
				col <= '0;
				row <= '0;
				newer_sel <= 1'b0;
			end else if (shift_en) begin
				if (col == COL_LAST) begin
					col <= '0;
					newer_sel <= ~newer_sel;     // Swap roles at end of row
					if (row != 2'd2)
						row <= row + 2'd1;
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

endmodule

//--- verilog/conv_pe.sv
`include "cnn_consts.svh"

module conv_pe
	import cnn_data_pkg::*, cnn_ctrl_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  pixel_t  win [9],
	input  logic    win_valid,
	input  weight_t weights [9],
	input  bias_t   bias,
	input  shift_t  shift,
	input  logic    relu,
	input  logic    stall,
	output result_t res,
	output logic    res_valid,
	output logic    pe_busy
);

	localparam acc_t RES_MAX = acc_t'((1 << (`RES_W - 1)) - 1);
	localparam acc_t RES_MIN = -RES_MAX - acc_t'(1);

	product_t prod [9];
	acc_t sum_c;
	acc_t sum_q;
	acc_t biased;
	acc_t shifted;
	result_t res_c;
	logic v1;
	logic v2;

	// Input window counts too, so DRAIN cannot end under it
	assign pe_busy = win_valid || v1 || v2 || res_valid;

	always_comb begin
		sum_c = '0;
		for (int i = 0; i < 9; i++)
			sum_c = sum_c + acc_t'(prod[i]);
	end

	always_comb begin
		biased = sum_q + acc_t'(bias);
		shifted = biased >>> shift;
		if (relu && shifted[$bits(acc_t)-1])
			res_c = '0;
		else if (shifted > RES_MAX)
			res_c = result_t'(RES_MAX);
		else if (shifted < RES_MIN)
			res_c = result_t'(RES_MIN);
		else
			res_c = result_t'(shifted);
	end

	////////////////////////////////////////////////////////////////////////////
	// Pipeline, frozen as a whole by stall
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!stall) begin
			for (int i = 0; i < 9; i++)
				prod[i] <= product_t'($signed({1'b0, win[i]})) * product_t'(weights[i]);
			sum_q <= sum_c;
			res <= res_c;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			res_valid <= 1'b0;
		end else if (!stall) begin
			v1 <= win_valid;     // Products
			v2 <= v1;            // Sum
			res_valid <= v2;
		end
	end

endmodule

//--- verilog/conv_top.sv
module conv_top
	import cnn_data_pkg::*, cnn_ctrl_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    inst_empty,
	input  inst_t   inst,
	output logic    inst_req,
	input  logic    pix_valid,
	input  pixel_t  pix,
	output logic    pix_ready,
	output logic    res_valid,
	output result_t res,
	input  logic    res_ready
);

	logic stall;
	logic pix_take;
	logic frame_start;
	logic pe_busy;
	logic win_valid;
	pixel_t win [9];
	weight_t weights [9];
	bias_t bias;
	shift_t shift;
	logic relu;

	// Output held back, whole datapath waits
	assign stall = res_valid && !res_ready;
	assign pix_take = pix_valid && pix_ready;

	inst_decode u_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.inst_empty  (inst_empty),
		.inst        (inst),
		.inst_req    (inst_req),
		.pix_valid   (pix_valid),
		.stall       (stall),
		.pe_busy     (pe_busy),
		.pix_ready   (pix_ready),
		.frame_start (frame_start),
		.weights     (weights),
		.bias        (bias),
		.shift       (shift),
		.relu        (relu)
	);

	line_window u_window (
		.clk         (clk),
		.rst_n       (rst_n),
		.frame_start (frame_start),
		.pix         (pix),
		.pix_take    (pix_take),
		.stall       (stall),
		.win         (win),
		.win_valid   (win_valid)
	);

	conv_pe u_pe (
		.clk       (clk),
		.rst_n     (rst_n),
		.win       (win),
		.win_valid (win_valid),
		.weights   (weights),
		.bias      (bias),
		.shift     (shift),
		.relu      (relu),
		.stall     (stall),
		.res       (res),
		.res_valid (res_valid),
		.pe_busy   (pe_busy)
	);

endmodule

//--- sim/conv_sva.sv
module conv_sva
	import cnn_data_pkg::*;
(
	input logic    clk,
	input logic    rst_n,
	input logic    inst_empty,
	input logic    inst_req,
	input logic    pix_ready,
	input logic    res_valid,
	input result_t res,
	input logic    res_ready
);

	int fail_cnt = 0;

	// Held result must not move
	a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid && !res_ready |=> res_valid && $stable(res))
	else begin
		fail_cnt++;
		$error("res or res_valid changed while res_ready was low");
	end

	a_req_empty: assert property (@(posedge clk) disable iff (!rst_n)
		!(inst_req && inst_empty))
	else begin
		fail_cnt++;
		$error("inst_req raised with the instruction FIFO empty");
	end

	a_reset_state: assert property (@(posedge clk)
		!rst_n |=> !inst_req && !pix_ready && !res_valid)
	else begin
		fail_cnt++;
		$error("outputs not low in the cycle after reset");
	end

endmodule

//--- sim/conv_checker.sv
`include "cnn_consts.svh"

module conv_checker
	import cnn_data_pkg::*, cnn_ctrl_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  inst_t   inst,
	input  logic    inst_req,
	input  logic    pix_valid,
	input  pixel_t  pix,
	input  logic    pix_ready,
	input  logic    res_valid,
	input  result_t res,
	input  logic    res_ready,
	input  logic    end_run,
	output int      err_cnt,
	output int      res_cnt
);

	weight_t cfg_w [9];         // Taps of the frame being received
	bias_t cfg_b;
	shift_t cfg_s;
	logic cfg_relu;
	pixel_t img [256][`LINE_LEN];
	result_t exp_q [$];
	result_t want;
	int row;
	int col;
	int n_inst;
	int n_err;
	int n_res;
	logic end_seen;

	assign err_cnt = n_err;
	assign res_cnt = n_res;

	// Dot product, bias, arithmetic shift, ReLU, then clamp to 16 bits
	function automatic result_t conv_ref(input int r, input int c);
		int acc;
		acc = 0;
		for (int k = 0; k < 9; k++)
			acc += int'(img[r - 2 + k/3][c - 2 + k%3]) * int'(cfg_w[k]);
		acc = acc + int'(cfg_b);
		acc = acc >>> cfg_s;
		if (cfg_relu && acc < 0)
			acc = 0;
		if (acc > 32767)
			acc = 32767;
		else if (acc < -32768)
			acc = -32768;
		return result_t'(acc);
	endfunction

	initial begin
		n_inst = 0;
		n_err = 0;
		n_res = 0;
		end_seen = 1'b0;
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			row = 0;
			col = 0;
		end else begin
			if (inst_req) begin
				for (int k = 0; k < 9; k++)
					cfg_w[k] = weight_t'(inst[`INST_WGT_LSB + k*`WGT_W +: `WGT_W]);
				cfg_b = bias_t'(inst[`INST_BIAS_LSB +: `BIAS_W]);
				cfg_s = shift_t'(inst[`INST_SHIFT_LSB +: `SHIFT_W]);
				cfg_relu = inst[`INST_RELU_BIT];
				n_inst++;
				row = 0;
				col = 0;
			end
			if (pix_valid && pix_ready) begin
				img[row][col] = pix;
				if (row >= 2 && col >= 2)
					exp_q.push_back(conv_ref(row, col));
				if (col == `LINE_LEN - 1) begin
					col = 0;
					row++;
				end else begin
					col++;
				end
			end
			if (res_valid && res_ready) begin
				n_res++;
				if (exp_q.size() == 0) begin
					$display("extra result %0d at %0t with no expected value left", res, $time);
					n_err++;
				end else begin
					want = exp_q.pop_front();
					if (res !== want) begin
						$display("mismatch at %0t: res is %0d, expected %0d", $time, res, want);
						n_err++;
					end
				end
			end
			if (end_run && !end_seen) begin
				end_seen = 1'b1;
				if (exp_q.size() != 0) begin
					$display("%0d expected results never came out after %0d instructions",
						exp_q.size(), n_inst);
					n_err++;
				end
			end
		end
	end

endmodule

//--- sim/conv_tb.sv
`include "cnn_consts.svh"

module conv_tb
	import cnn_data_pkg::*, cnn_ctrl_pkg::*;
;

	logic clk;
	logic rst_n;
	logic inst_empty;
	inst_t inst;
	logic inst_req;
	logic pix_valid;
	pixel_t pix;
	logic pix_ready;
	logic res_valid;
	result_t res;
	logic res_ready;
	logic end_run;
	int err_cnt;
	int res_cnt;

	inst_t inst_q [$];          // Instruction FIFO model
	pixel_t pix_mem [$];        // Whole pixel stream, all frames
	weight_t taps [9];
	logic [31:0] rng;
	int total_res;
	int calm_len;               // Pixels sent without gaps
	int pix_idx;
	int cycles;
	int timeout_lim;

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic inst_t pack_inst(input weight_t w [9], input bias_t b, input shift_t s,
			input logic relu, input rows_t rows);
		inst_t word;
		word = '0;
		for (int i = 0; i < 9; i++)
			word[`INST_WGT_LSB + i*`WGT_W +: `WGT_W] = w[i];
		word[`INST_BIAS_LSB +: `BIAS_W] = b;
		word[`INST_SHIFT_LSB +: `SHIFT_W] = s;
		word[`INST_RELU_BIT] = relu;
		word[`INST_ROWS_LSB +: `ROWS_W] = rows;
		return word;
	endfunction

	// Queues one instruction with the current taps and the pixels of its frame
	task automatic add_frame(input bias_t b, input shift_t s, input logic relu,
			input rows_t rows, input logic reuse);
		int base;
		base = pix_mem.size() - rows * `LINE_LEN;
		inst_q.push_back(pack_inst(taps, b, s, relu, rows));
		total_res += (rows - 2) * (`LINE_LEN - 2);
		for (int i = 0; i < rows * `LINE_LEN; i++) begin
			if (reuse) begin
				pix_mem.push_back(pix_mem[base + i]);
			end else begin
				rng = xorshift(rng);
				pix_mem.push_back(pixel_t'(rng[15:8]));
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// DUT and checker
	////////////////////////////////////////////////////////////////////////////

	conv_top DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst_empty (inst_empty),
		.inst       (inst),
		.inst_req   (inst_req),
		.pix_valid  (pix_valid),
		.pix        (pix),
		.pix_ready  (pix_ready),
		.res_valid  (res_valid),
		.res        (res),
		.res_ready  (res_ready)
	);

	conv_checker u_checker (
		.clk       (clk),
		.rst_n     (rst_n),
		.inst      (inst),
		.inst_req  (inst_req),
		.pix_valid (pix_valid),
		.pix       (pix),
		.pix_ready (pix_ready),
		.res_valid (res_valid),
		.res       (res),
		.res_ready (res_ready),
		.end_run   (end_run),
		.err_cnt   (err_cnt),
		.res_cnt   (res_cnt)
	);

	bind conv_top conv_sva u_sva (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst_empty (inst_empty),
		.inst_req   (inst_req),
		.pix_ready  (pix_ready),
		.res_valid  (res_valid),
		.res        (res),
		.res_ready  (res_ready)
	);

	always #2 clk = ~clk;

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		inst_empty = 1'b1;
		inst = '0;
		pix_valid = 1'b0;
		pix = '0;
		res_ready = 1'b0;
		rng = 32'hd789_778b;
		total_res = 0;
		pix_idx = 0;

		// Centre tap only, result is centre pixel plus 5
		for (int i = 0; i < 9; i++)
			taps[i] = '0;
		taps[4] = 8'sd1;
		add_frame(16'sd5, 4'd0, 1'b0, 8'd5, 1'b0);
		calm_len = pix_mem.size();

		// Large taps, five negative and four positive, against a negative bias
		for (int i = 0; i < 9; i++) begin
			rng = xorshift(rng);
			taps[i] = weight_t'({2'b01, rng[5:0]});
			if (i < 5)
				taps[i] = -taps[i];
		end
		add_frame(-16'sd20000, 4'd0, 1'b0, 8'd6, 1'b0);
		add_frame(-16'sd20000, 4'd0, 1'b1, 8'd6, 1'b1);     // Same frame with ReLU

		// Back-to-back frames, each with its own row count and taps
		for (int f = 0; f < 3; f++) begin
			for (int i = 0; i < 9; i++) begin
				rng = xorshift(rng);
				taps[i] = weight_t'(rng[7:0]);
			end
			rng = xorshift(rng);
			add_frame(bias_t'(rng[15:0]), shift_t'(rng[17:16]) + 4'd2, rng[20],
				rows_t'(3 + f*2), 1'b0);
		end
		timeout_lim = 4 * pix_mem.size() + 200;

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		forever begin
			@(posedge clk);
			if (inst_req)
				void'(inst_q.pop_front());     // Word taken on this edge
			if (pix_valid && pix_ready)
				pix_idx++;
			inst_empty <= (inst_q.size() == 0);
			if (inst_q.size() != 0)
				inst <= inst_q[0];
			if (!pix_valid || pix_ready) begin
				rng = xorshift(rng);
				if (pix_idx < pix_mem.size()) begin
					pix_valid <= (pix_idx < calm_len) || (rng[1:0] != 2'd0);
					pix <= pix_mem[pix_idx];
				end else begin
					pix_valid <= 1'b0;
				end
			end
			rng = xorshift(rng);
			res_ready <= (pix_idx < calm_len) || (rng[3:2] != 2'd0);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// End of run
	////////////////////////////////////////////////////////////////////////////

	initial begin
		end_run = 1'b0;
		@(posedge rst_n);
		while (res_cnt < total_res)
			@(posedge clk);
		repeat (30) @(posedge clk);     // Room for any extra result
		end_run <= 1'b1;
		repeat (2) @(posedge clk);
		$display("results %0d of %0d, errors %0d, assertion failures %0d",
			res_cnt, total_res, err_cnt, DUT.u_sva.fail_cnt);
		if (err_cnt == 0 && DUT.u_sva.fail_cnt == 0 && res_cnt == total_res)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial cycles = 0;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_lim) begin
			$display("timeout after %0d cycles with %0d of %0d results seen",
				cycles, res_cnt, total_res);
			$display("TEST FAILED");
			$finish;
		end
	end

endmodule

//--- filelist.f
+incdir+verilog
verilog/cnn_data_pkg.sv
verilog/cnn_ctrl_pkg.sv
verilog/inst_decode.sv
verilog/line_window.sv
verilog/conv_pe.sv
verilog/conv_top.sv
sim/conv_sva.sv
sim/conv_checker.sv
sim/conv_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module conv_tb \
	-f filelist.f -o conv_sim \
	&& ./obj_dir/conv_sim | tee /dev/stderr | grep -qx "TEST OK" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
